//--- Makefile
# Verilator flow for the cache back end.

VERILATOR ?= verilator
TOP       ?= tb_cache_be
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/cache_back_end.sv
`timescale 1ns/1ns

module cache_back_end (
   input  logic                     clk_i,
   input  logic                     rst_n,
   input  logic                     write_valid,
   input  cache_be_pkg::word_addr_t write_addr,
   input  cache_be_pkg::data_t      write_wdata,
   input  cache_be_pkg::strb_t      write_wstrb,
   output logic                     write_ack,
   input  logic                     replace_valid,
   input  cache_be_pkg::line_addr_t replace_addr,
   output logic                     replace,
   output logic                     read_valid,
   output cache_be_pkg::word_off_t  read_addr,
   output cache_be_pkg::data_t      read_rdata,
   output logic                     be_valid,
   output cache_be_pkg::be_addr_t   be_addr,
   output cache_be_pkg::data_t      be_wdata,
   output cache_be_pkg::strb_t      be_wstrb,
   input  logic                     be_ready,
   input  logic                     be_rvalid,
   input  cache_be_pkg::data_t      be_rdata
);
   import cache_be_pkg::*;

   logic     be_valid_read, be_valid_write;
   be_addr_t be_addr_read, be_addr_write;
   strb_t    be_wstrb_write;
   logic     be_ready_write;

   // Refill reads always win the port.
   assign be_valid       = be_valid_read | be_valid_write;
   assign be_addr        = be_valid_read ? be_addr_read : be_addr_write;
   assign be_ready_write = be_ready & ~be_valid_read;
   assign be_wstrb       = (be_valid_write && !be_valid_read) ? be_wstrb_write : '0;

   cache_read_channel read_fsm (
      .clk_i        (clk_i),
      .rst_n        (rst_n),
      .replace_valid(replace_valid),
      .replace_addr (replace_addr),
      .replace      (replace),
      .read_valid   (read_valid),
      .read_addr    (read_addr),
      .read_rdata   (read_rdata),
      .be_valid     (be_valid_read),
      .be_addr      (be_addr_read),
      .be_ready     (be_ready),
      .be_rvalid    (be_rvalid),
      .be_rdata     (be_rdata)
   );

   cache_write_channel write_fsm (
      .clk_i   (clk_i),
      .rst_n   (rst_n),
      .valid   (write_valid),
      .addr    (write_addr),
      .wdata   (write_wdata),
      .wstrb   (write_wstrb),
      .wack    (write_ack),
      .be_valid(be_valid_write),
      .be_addr (be_addr_write),
      .be_wdata(be_wdata),
      .be_wstrb(be_wstrb_write),
      .be_ready(be_ready_write)
   );

endmodule

//--- rtl/cache_be_pkg.sv
package cache_be_pkg;

   localparam int fe_addr_w  = 24;  // Byte address width on both buses.
   localparam int data_w     = 32;
   localparam int nbytes     = 4;
   localparam int word_off_w = 2;   // Four words per line.
   localparam int wbuf_depth = 4;

   typedef logic [data_w-1:0] data_t;
   typedef logic [nbytes-1:0] strb_t;

   // The word address is byte address bits 23 to 2.
   typedef logic [fe_addr_w-$clog2(nbytes)-1:0] word_addr_t;

   // The line address is byte address bits 23 to 4.
   typedef logic [fe_addr_w-$clog2(nbytes)-word_off_w-1:0] line_addr_t;

   typedef logic [word_off_w-1:0] word_off_t;

   // The low two bits are always zero on the memory bus.
   typedef logic [fe_addr_w-1:0] be_addr_t;

   typedef enum logic [1:0] {
      rd_idle,
      rd_req,
      rd_wait,
      rd_done
   } read_state_t;

   typedef enum logic {
      wr_idle,
      wr_req
   } write_state_t;

endpackage

//--- rtl/cache_be_top.sv
`timescale 1ns/1ns

module cache_be_top (
   input  logic                     clk_i,
   input  logic                     rst_n,
   input  logic                     wr_valid,
   input  cache_be_pkg::word_addr_t wr_addr,
   input  cache_be_pkg::data_t      wr_wdata,
   input  cache_be_pkg::strb_t      wr_wstrb,
   output logic                     wr_ready,
   input  logic                     replace_valid,
   input  cache_be_pkg::line_addr_t replace_addr,
   output logic                     replace,
   output logic                     read_valid,
   output cache_be_pkg::word_off_t  read_addr,
   output cache_be_pkg::data_t      read_rdata,
   output logic                     be_valid,
   output cache_be_pkg::be_addr_t   be_addr,
   output cache_be_pkg::data_t      be_wdata,
   output cache_be_pkg::strb_t      be_wstrb,
   input  logic                     be_ready,
   input  logic                     be_rvalid,
   input  cache_be_pkg::data_t      be_rdata
);
   import cache_be_pkg::*;

   logic       write_valid;
   word_addr_t write_addr;
   data_t      write_wdata;
   strb_t      write_wstrb;
   logic       write_ack;

   write_buffer i_wbuf (
      .clk_i      (clk_i),
      .rst_n      (rst_n),
      .wr_valid   (wr_valid),
      .wr_addr    (wr_addr),
      .wr_wdata   (wr_wdata),
      .wr_wstrb   (wr_wstrb),
      .wr_ready   (wr_ready),
      .write_valid(write_valid),
      .write_addr (write_addr),
      .write_wdata(write_wdata),
      .write_wstrb(write_wstrb),
      .write_ack  (write_ack)
   );

   cache_back_end i_back_end (
      .clk_i        (clk_i),
      .rst_n        (rst_n),
      .write_valid  (write_valid),
      .write_addr   (write_addr),
      .write_wdata  (write_wdata),
      .write_wstrb  (write_wstrb),
      .write_ack    (write_ack),
      .replace_valid(replace_valid),
      .replace_addr (replace_addr),
      .replace      (replace),
      .read_valid   (read_valid),
      .read_addr    (read_addr),
      .read_rdata   (read_rdata),
      .be_valid     (be_valid),
      .be_addr      (be_addr),
      .be_wdata     (be_wdata),
      .be_wstrb     (be_wstrb),
      .be_ready     (be_ready),
      .be_rvalid    (be_rvalid),
      .be_rdata     (be_rdata)
   );

endmodule

//--- rtl/cache_read_channel.sv
`timescale 1ns/1ns

module cache_read_channel (
   input  logic                     clk_i,
   input  logic                     rst_n,
   input  logic                     replace_valid,
   input  cache_be_pkg::line_addr_t replace_addr,
   output logic                     replace,
   output logic                     read_valid,
   output cache_be_pkg::word_off_t  read_addr,
   output cache_be_pkg::data_t      read_rdata,
   output logic                     be_valid,
   output cache_be_pkg::be_addr_t   be_addr,
   input  logic                     be_ready,
   input  logic                     be_rvalid,
   input  cache_be_pkg::data_t      be_rdata
);
   import cache_be_pkg::*;

   read_state_t state;
   line_addr_t  line_q;
   word_off_t   word_cnt;

   always_ff @(posedge clk_i) begin
      if (!rst_n) begin
         state    <= rd_idle;
         word_cnt <= '0;
      end else begin
         case (state)
            rd_idle: begin
               if (replace_valid) begin
                  state    <= rd_req;
                  word_cnt <= '0;
               end
            end
            rd_req: begin
               if (be_ready) state <= rd_wait;
            end
            rd_wait: begin
               if (be_rvalid) begin
                  if (&word_cnt) begin
                     state <= rd_done;  // Last word of the line is back.
                  end else begin
                     state    <= rd_req;
                     word_cnt <= word_cnt + 1'b1;
                  end
               end
            end
            default: state <= rd_idle;  // rd_done lets replace fall next cycle.
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n) begin
         read_valid <= 1'b0;
      end else begin
         read_valid <= (state == rd_wait) && be_rvalid;
      end
   end

   always_ff @(posedge clk_i) begin
      if (state == rd_idle && replace_valid) line_q <= replace_addr;
      if (state == rd_wait && be_rvalid) begin
         read_addr  <= word_cnt;
         read_rdata <= be_rdata;
      end
   end

   assign replace  = (state != rd_idle);
   assign be_valid = (state == rd_req);
   assign be_addr  = {line_q, word_cnt, {$clog2(nbytes){1'b0}}};

   // Only one read is ever outstanding, so the memory may answer only while we wait.
   a_rvalid_in_wait : assert property (@(posedge clk_i) disable iff (!rst_n)
      be_rvalid |-> state == rd_wait)
      else $error("be_rvalid seen outside rd_wait");

endmodule

//--- rtl/cache_write_channel.sv
`timescale 1ns/1ns

module cache_write_channel (
   input  logic                     clk_i,
   input  logic                     rst_n,
   input  logic                     valid,
   input  cache_be_pkg::word_addr_t addr,
   input  cache_be_pkg::data_t      wdata,
   input  cache_be_pkg::strb_t      wstrb,
   output logic                     wack,
   output logic                     be_valid,
   output cache_be_pkg::be_addr_t   be_addr,
   output cache_be_pkg::data_t      be_wdata,
   output cache_be_pkg::strb_t      be_wstrb,
   input  logic                     be_ready
);
   import cache_be_pkg::*;

   write_state_t state;
   word_addr_t   addr_q;
   data_t        wdata_q;
   strb_t        wstrb_q;
   logic         take;

   // The head is still valid in the ack cycle, since the buffer pops on wack.
   assign take = (state == wr_idle) && valid && !wack;

   always_ff @(posedge clk_i) begin
      if (!rst_n) begin
         state <= wr_idle;
         wack  <= 1'b0;
      end else begin
         wack <= 1'b0;
         case (state)
            wr_idle: begin
               if (take) state <= wr_req;
            end
            default: begin
               if (be_ready) begin
                  state <= wr_idle;
                  wack  <= 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (take) begin
         addr_q  <= addr;
         wdata_q <= wdata;
         wstrb_q <= wstrb;
      end
   end

   assign be_valid = (state == wr_req);
   assign be_addr  = {addr_q, {$clog2(nbytes){1'b0}}};
   assign be_wdata = wdata_q;
   assign be_wstrb = wstrb_q;

   // A pending write must survive a stall, including one caused by read priority.
   a_hold_request : assert property (@(posedge clk_i) disable iff (!rst_n)
      be_valid && !be_ready |=> be_valid && $stable(be_addr) && $stable(be_wdata)
         && $stable(be_wstrb))
      else $error("write request changed while stalled");

endmodule

//--- rtl/write_buffer.sv
`timescale 1ns/1ns

module write_buffer (
   input  logic                     clk_i,
   input  logic                     rst_n,
   input  logic                     wr_valid,
   input  cache_be_pkg::word_addr_t wr_addr,
   input  cache_be_pkg::data_t      wr_wdata,
   input  cache_be_pkg::strb_t      wr_wstrb,
   output logic                     wr_ready,
   output logic                     write_valid,
   output cache_be_pkg::word_addr_t write_addr,
   output cache_be_pkg::data_t      write_wdata,
   output cache_be_pkg::strb_t      write_wstrb,
   input  logic                     write_ack
);
   import cache_be_pkg::*;

   typedef logic [$clog2(wbuf_depth)-1:0] ptr_t;
   typedef logic [$clog2(wbuf_depth):0]   cnt_t;

   word_addr_t addr_mem [wbuf_depth];
   data_t      data_mem [wbuf_depth];
   strb_t      strb_mem [wbuf_depth];
   ptr_t       wr_ptr, rd_ptr;
   cnt_t       count;
   logic       push, pop;

   assign wr_ready    = (count != cnt_t'(wbuf_depth));
   assign write_valid = (count != '0);
   assign push        = wr_valid && wr_ready;
   assign pop         = write_ack && write_valid;

   always_ff @(posedge clk_i) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, so it wraps.
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         addr_mem[wr_ptr] <= wr_addr;
         data_mem[wr_ptr] <= wr_wdata;
         strb_mem[wr_ptr] <= wr_wstrb;
      end
   end

   assign write_addr  = addr_mem[rd_ptr];
   assign write_wdata = data_mem[rd_ptr];
   assign write_wstrb = strb_mem[rd_ptr];

   a_ack_has_entry : assert property (@(posedge clk_i) disable iff (!rst_n)
      write_ack |-> write_valid)
      else $error("write_ack with an empty buffer");

endmodule

//--- test/mem_model.sv
`timescale 1ns/1ns

module mem_model #(
   parameter int words = 4096
) (
   input  logic                   clk_i,
   input  logic                   rst_n,
   input  int                     stall_pct,
   input  logic                   be_valid,
   input  cache_be_pkg::be_addr_t be_addr,
   input  cache_be_pkg::data_t    be_wdata,
   input  cache_be_pkg::strb_t    be_wstrb,
   output logic                   be_ready,
   output logic                   be_rvalid,
   output cache_be_pkg::data_t    be_rdata
);
   import cache_be_pkg::*;

   data_t mem [words];
   int    wr_count;     // Bus writes accepted so far.
   logic  rd_pending;
   int    rd_delay;
   data_t rd_word;
   int    wa;

   initial begin
      for (int i = 0; i < words; i++) begin
         mem[i] = 32'(i) ^ 32'hA5A5_0000;  // The fill follows the full word address.
      end
      wr_count   = 0;
      rd_pending = 1'b0;
      be_ready   = 1'b0;
      be_rvalid  = 1'b0;
      be_rdata   = '0;
   end

   // Requests are taken on the rising edge, as the DUT sees them.
   always @(posedge clk_i) begin
      if (rst_n && be_valid && be_ready) begin
         wa = int'(be_addr >> 2) % words;
         if (be_wstrb != '0) begin
            for (int b = 0; b < nbytes; b++) begin
               if (be_wstrb[b]) mem[wa][8*b +: 8] = be_wdata[8*b +: 8];
            end
            wr_count++;
         end else begin
            rd_word    = mem[wa];
            rd_delay   = 1 + $urandom_range(2);
            rd_pending = 1'b1;
         end
      end
   end

   // Responses and stalls change on the falling edge.
   always @(negedge clk_i) begin
      be_rvalid = 1'b0;
      if (rd_pending) begin
         rd_delay--;
         if (rd_delay == 0) begin
            be_rvalid  = 1'b1;
            be_rdata   = rd_word;
            rd_pending = 1'b0;
         end
      end
      be_ready = ($urandom_range(99) >= stall_pct);
   end

endmodule

//--- test/tb_cache_be.sv
`timescale 1ns/1ns

module tb_cache_be;
   import cache_be_pkg::*;

   localparam int mem_words  = 4096;
   localparam int wait_limit = 2000;

   logic       clk_i, rst_n;
   logic       wr_valid, wr_ready;
   word_addr_t wr_addr;
   data_t      wr_wdata;
   strb_t      wr_wstrb;
   logic       replace_valid, replace, read_valid;
   line_addr_t replace_addr;
   word_off_t  read_addr;
   data_t      read_rdata;
   logic       be_valid, be_ready, be_rvalid;
   be_addr_t   be_addr;
   data_t      be_wdata, be_rdata;
   strb_t      be_wstrb;
   int         stall_pct;

   data_t      shadow [mem_words];  // Expected memory image.
   int         errors, tests, failed, start_errors;
   int         accepted, rd_count;
   line_addr_t exp_line;
   logic       saw_full;

   cache_be_top i_cache_be_top (.*);
   mem_model i_mem (.*);

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   function automatic data_t pattern(int word);
      return 32'(word) ^ 32'hA5A5_0000;
   endfunction

   function automatic data_t merge(data_t old, data_t data, strb_t strb);
      data_t res;
      res = old;
      for (int b = 0; b < nbytes; b++) begin
         if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
      end
      return res;
   endfunction

   task automatic expect_val(string name, logic [31:0] got, logic [31:0] exp);
      assert (got === exp) else begin
         $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic report();
      $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   endtask

   task automatic timed_out(string what);
      $display("timeout at %0t ns while waiting for %s", $time, what);
      errors++;
      tests++;
      failed++;
      report();
   endtask

   task automatic end_test(string name);
      tests++;
      if (errors == start_errors) begin
         $display("test %0d %s: passed", tests, name);
      end else begin
         failed++;
         $display("test %0d %s: failed with %0d errors", tests, name, errors - start_errors);
      end
      start_errors = errors;
   endtask

   // Starts on a falling edge and returns on the falling edge after the handshake.
   task automatic push_write(word_addr_t addr, data_t data, strb_t strb);
      int n;
      wr_valid = 1'b1;
      wr_addr  = addr;
      wr_wdata = data;
      wr_wstrb = strb;
      n = 0;
      while (!wr_ready && n < wait_limit) begin
         saw_full = 1'b1;
         @(negedge clk_i);
         n++;
      end
      if (!wr_ready) timed_out("wr_ready");
      @(negedge clk_i);
      wr_valid = 1'b0;
      shadow[int'(addr)] = merge(shadow[int'(addr)], data, strb);
      accepted++;
   endtask

   task automatic drain_writes();
      int n;
      n = 0;
      while ((i_cache_be_top.write_valid || be_valid) && n < wait_limit) begin
         @(negedge clk_i);
         n++;
      end
      if (i_cache_be_top.write_valid || be_valid) timed_out("the write buffer to drain");
   endtask

   task automatic refill(line_addr_t line);
      int n;
      exp_line      = line;
      rd_count      = 0;
      replace_valid = 1'b1;
      replace_addr  = line;
      n = 0;
      while (!replace && n < wait_limit) begin
         @(negedge clk_i);
         n++;
      end
      if (!replace) timed_out("replace to rise");
      replace_valid = 1'b0;
      n = 0;
      while (replace && n < wait_limit) begin
         @(negedge clk_i);
         n++;
      end
      if (replace) timed_out("replace to fall");
      expect_val("read_valid pulses", rd_count, 4);
   endtask

   task automatic check_mem(int lo, int hi);
      for (int a = lo; a < hi; a++) begin
         expect_val($sformatf("mem[%0d]", a), i_mem.mem[a], shadow[a]);
      end
   endtask

   // Every returned refill word is checked against the fill pattern.
   always @(negedge clk_i) begin
      if (rst_n && read_valid) begin
         expect_val("read_addr", 32'(read_addr), 32'(rd_count % 4));
         expect_val("read_rdata", read_rdata, pattern(int'(exp_line) * 4 + rd_count));
         rd_count++;
      end
   end

   initial begin
      int base;
      int acc0;
      void'($urandom(32'h19981509));
      rst_n         = 1'b0;
      wr_valid      = 1'b0;
      wr_addr       = '0;
      wr_wdata      = '0;
      wr_wstrb      = '0;
      replace_valid = 1'b0;
      replace_addr  = '0;
      stall_pct     = 30;
      errors        = 0;
      tests         = 0;
      failed        = 0;
      start_errors  = 0;
      accepted      = 0;
      rd_count      = 0;
      exp_line      = '0;
      saw_full      = 1'b0;
      for (int i = 0; i < mem_words; i++) begin
         shadow[i] = pattern(i);
      end
      repeat (16) @(negedge clk_i);
      rst_n = 1'b1;
      @(negedge clk_i);

      expect_val("be_valid", 32'(be_valid), 0);
      expect_val("replace", 32'(replace), 0);
      expect_val("read_valid", 32'(read_valid), 0);
      expect_val("write_valid", 32'(i_cache_be_top.write_valid), 0);
      expect_val("wr_ready", 32'(wr_ready), 1);
      end_test("reset");

      for (int i = 0; i < 8; i++) begin
         push_write(word_addr_t'(i * 8 + $urandom_range(7)), $urandom,
                    strb_t'(1 + $urandom_range(14)));
      end
      drain_writes();
      check_mem(0, 64);
      end_test("write-through merge");

      refill(line_addr_t'(512 + $urandom_range(511)));
      end_test("line refill");

      stall_pct = 100;  // Hold the bus so that the buffer fills up.
      for (int i = 0; i < wbuf_depth; i++) begin
         push_write(word_addr_t'(64 + i * 4 + $urandom_range(3)), $urandom,
                    strb_t'(1 + $urandom_range(14)));
      end
      expect_val("wr_ready", 32'(wr_ready), 0);
      stall_pct = 30;
      refill(line_addr_t'(512 + $urandom_range(511)));
      drain_writes();
      check_mem(64, 128);
      end_test("read priority under load");

      stall_pct = 85;
      saw_full  = 1'b0;
      base      = i_mem.wr_count;
      acc0      = accepted;
      for (int i = 0; i < 20; i++) begin
         push_write(word_addr_t'(128 + i), $urandom, strb_t'(1 + $urandom_range(14)));
      end
      assert (saw_full) else begin
         $display("wr_ready never fell while writes were pending");
         errors++;
      end
      stall_pct = 30;
      drain_writes();
      expect_val("bus writes", i_mem.wr_count - base, accepted - acc0);
      check_mem(128, 148);
      end_test("back-pressure");

      check_mem(0, mem_words);
      end_test("memory image");
      report();
   end

endmodule

//--- vlog.f
rtl/cache_be_pkg.sv
rtl/cache_read_channel.sv
rtl/cache_write_channel.sv
rtl/cache_back_end.sv
rtl/write_buffer.sv
rtl/cache_be_top.sv
test/mem_model.sv
test/tb_cache_be.sv
